// File: rtl/ldpc_sched_pkg.sv
package ldpc_sched_pkg;

	////////////////////////////////////////////////////////////
	// decoder geometry
	////////////////////////////////////////////////////////////
	localparam int QUAN_SIZE          = 4; // llr width, also serial cycles per message
	localparam int CNU_PIPELINE_LEVEL = 4; // check-node pipeline stages
	localparam int VNU_PIPELINE_LEVEL = 2; // variable-node pipeline stages

	localparam logic INIT_INTER_FRAME_EN = 1'b0; // inter_frame_en value while fsm held off

	////////////////////////////////////////////////////////////
	// schedule states
	////////////////////////////////////////////////////////////
	typedef enum logic [3:0] {
		INIT_LOAD     = 4'd0,
		LLR_FETCH     = 4'd1,  // channel llrs shifted in
		LLR_FETCH_OUT = 4'd2,
		CNU_PIPE      = 4'd3,  // check-node pipeline running
		CNU_OUT       = 4'd4,
		P2P_C         = 4'd5,  // c2v serial transfer
		P2P_C_OUT     = 4'd6,
		VNU_PIPE      = 4'd7,  // variable-node pipeline running
		VNU_OUT       = 4'd8,
		P2P_V         = 4'd9,  // v2c serial transfer
		P2P_V_OUT     = 4'd10
	} sched_state_e;

	// one-hot bit position of a serial transfer, top bit is the park position
	typedef logic [QUAN_SIZE:0] psp_t;

	// one-hot pipeline levels
	typedef logic [CNU_PIPELINE_LEVEL-1:0] cnu_level_t;
	typedef logic [VNU_PIPELINE_LEVEL-1:0] vnu_level_t;

	localparam psp_t PSP_LOAD = psp_t'(1);                 // first bit of a transfer
	localparam psp_t PSP_PARK = {1'b1, {QUAN_SIZE{1'b0}}}; // idle, no transfer

endpackage

// File: rtl/sched_if.sv
`timescale 1ns/1ps

interface sched_if (
	input logic read_clk
);

	ldpc_sched_pkg::sched_state_e state; // current schedule state
	ldpc_sched_pkg::cnu_level_t cnu_level;
	ldpc_sched_pkg::vnu_level_t vnu_level;
	logic cnu_first; // first cycle of CNU_PIPE
	logic vnu_first; // first cycle of VNU_PIPE

	// serial transfer flags from the psp timers
	logic v2c_first;
	logic v2c_last;
	logic v2c_busy;
	logic c2v_first;
	logic c2v_last;
	logic c2v_busy;

	modport timer_mp (input read_clk, input state,
		output v2c_first, v2c_last, v2c_busy, c2v_first, c2v_last, c2v_busy);
	modport fsm_mp (input read_clk, output state, cnu_level, vnu_level, cnu_first, vnu_first,
		input v2c_first, v2c_last, v2c_busy, c2v_first, c2v_last, c2v_busy);
	modport strobe_mp (input read_clk, state, cnu_level, vnu_level, cnu_first, vnu_first,
		v2c_first, v2c_last, v2c_busy, c2v_first, c2v_last, c2v_busy);

endinterface

// File: rtl/msg_psp_timer.sv
`timescale 1ns/1ps

module msg_psp_timer (
	input logic read_clk,
	input logic rstn,
	sched_if.timer_mp sched
);

	ldpc_sched_pkg::psp_t v2c_psp; // v2c position, one-hot
	ldpc_sched_pkg::psp_t c2v_psp; // c2v position, one-hot
	logic v2c_busy_q;
	logic c2v_busy_q;
	logic v2c_load;
	logic v2c_shift;
	logic c2v_load;
	logic c2v_shift;

	// load wins over shift, otherwise park at top bit
	function automatic ldpc_sched_pkg::psp_t psp_next(input logic load, input logic shift,
		input ldpc_sched_pkg::psp_t cur);
		if (load)
			psp_next = ldpc_sched_pkg::PSP_LOAD;
		else if (shift)
			psp_next = {cur[ldpc_sched_pkg::QUAN_SIZE-1:0], 1'b0};
		else
			psp_next = ldpc_sched_pkg::PSP_PARK;
	endfunction

	always_comb begin
		v2c_load  = (sched.state == ldpc_sched_pkg::INIT_LOAD) ||
			(sched.state == ldpc_sched_pkg::VNU_OUT); // channel llrs or vnu results
		v2c_shift = (sched.state == ldpc_sched_pkg::LLR_FETCH) ||
			(sched.state == ldpc_sched_pkg::P2P_V);
		c2v_load  = (sched.state == ldpc_sched_pkg::CNU_OUT);
		c2v_shift = (sched.state == ldpc_sched_pkg::P2P_C);
	end

	always_ff @(posedge read_clk or negedge rstn) begin
		if (!rstn) begin
			v2c_psp    <= ldpc_sched_pkg::PSP_PARK;
			c2v_psp    <= ldpc_sched_pkg::PSP_PARK;
			v2c_busy_q <= 1'b0;
			c2v_busy_q <= 1'b0;
		end else begin
			v2c_psp    <= psp_next(v2c_load, v2c_shift, v2c_psp);
			c2v_psp    <= psp_next(c2v_load, c2v_shift, c2v_psp);
			v2c_busy_q <= ~v2c_psp[ldpc_sched_pkg::QUAN_SIZE]; // busy until parked again
			c2v_busy_q <= ~c2v_psp[ldpc_sched_pkg::QUAN_SIZE];
		end
	end

	assign sched.v2c_first = (v2c_psp == ldpc_sched_pkg::PSP_LOAD);
	assign sched.v2c_last  = v2c_psp[ldpc_sched_pkg::QUAN_SIZE-1]; // last bit being moved
	assign sched.v2c_busy  = v2c_busy_q;
	assign sched.c2v_first = (c2v_psp == ldpc_sched_pkg::PSP_LOAD);
	assign sched.c2v_last  = c2v_psp[ldpc_sched_pkg::QUAN_SIZE-1];
	assign sched.c2v_busy  = c2v_busy_q;

endmodule

// File: rtl/decode_fsm.sv
`timescale 1ns/1ps

module decode_fsm (
	input logic read_clk,
	input logic rstn,
	input logic fsm_en_i,
	input logic termination_i,       // current frame decoded
	input logic inter_frame_align_i, // other frame has caught up
	output logic inter_frame_en_o,
	output logic de_frame_start_o,
	sched_if.fsm_mp sched
);

	localparam int CNL = ldpc_sched_pkg::CNU_PIPELINE_LEVEL;
	localparam int VNL = ldpc_sched_pkg::VNU_PIPELINE_LEVEL;

	ldpc_sched_pkg::sched_state_e state_q;
	ldpc_sched_pkg::sched_state_e state_d;
	ldpc_sched_pkg::cnu_level_t cnu_level_q;
	ldpc_sched_pkg::vnu_level_t vnu_level_q;
	logic cnu_first;
	logic vnu_first;
	logic cnu_exit; // last cnu level before CNU_OUT
	logic vnu_exit;

	assign cnu_first = (state_q == ldpc_sched_pkg::CNU_PIPE) && (cnu_level_q == '0);
	assign vnu_first = (state_q == ldpc_sched_pkg::VNU_PIPE) && (vnu_level_q == '0);
	assign cnu_exit  = cnu_level_q[CNL-2];
	assign vnu_exit  = vnu_level_q[VNL-2];

	////////////////////////////////////////////////////////////
	// schedule state machine
	////////////////////////////////////////////////////////////
	always_comb begin
		state_d = state_q;
		if (!fsm_en_i || termination_i) begin
			state_d = ldpc_sched_pkg::INIT_LOAD; // hold or restart
		end else begin
			case (state_q)
				ldpc_sched_pkg::INIT_LOAD:     state_d = ldpc_sched_pkg::LLR_FETCH;
				ldpc_sched_pkg::LLR_FETCH:     if (sched.v2c_last) state_d = ldpc_sched_pkg::LLR_FETCH_OUT;
				ldpc_sched_pkg::LLR_FETCH_OUT: state_d = ldpc_sched_pkg::CNU_PIPE;
				ldpc_sched_pkg::CNU_PIPE:      if (cnu_exit) state_d = ldpc_sched_pkg::CNU_OUT;
				ldpc_sched_pkg::CNU_OUT:       state_d = ldpc_sched_pkg::P2P_C;
				ldpc_sched_pkg::P2P_C:         if (sched.c2v_last) state_d = ldpc_sched_pkg::P2P_C_OUT;
				ldpc_sched_pkg::P2P_C_OUT:     state_d = ldpc_sched_pkg::VNU_PIPE;
				ldpc_sched_pkg::VNU_PIPE:      if (vnu_exit) state_d = ldpc_sched_pkg::VNU_OUT;
				ldpc_sched_pkg::VNU_OUT:       state_d = ldpc_sched_pkg::P2P_V;
				ldpc_sched_pkg::P2P_V:         if (sched.v2c_last) state_d = ldpc_sched_pkg::P2P_V_OUT;
				ldpc_sched_pkg::P2P_V_OUT:     state_d = ldpc_sched_pkg::CNU_PIPE; // next iteration
				default:                       state_d = ldpc_sched_pkg::INIT_LOAD;
			endcase
		end
	end

	always_ff @(posedge read_clk or negedge rstn) begin
		if (!rstn) begin
			state_q     <= ldpc_sched_pkg::INIT_LOAD;
			cnu_level_q <= '0;
			vnu_level_q <= '0;
		end else begin
			state_q <= state_d;
			// one-hot level walks only inside its pipe state
			if (cnu_first)
				cnu_level_q <= ldpc_sched_pkg::cnu_level_t'(1);
			else if (state_q == ldpc_sched_pkg::CNU_PIPE)
				cnu_level_q <= {cnu_level_q[CNL-2:0], 1'b0};
			else
				cnu_level_q <= '0;
			if (vnu_first)
				vnu_level_q <= ldpc_sched_pkg::vnu_level_t'(1);
			else if (state_q == ldpc_sched_pkg::VNU_PIPE)
				vnu_level_q <= {vnu_level_q[VNL-2:0], 1'b0};
			else
				vnu_level_q <= '0;
		end
	end

	////////////////////////////////////////////////////////////
	// frame flags
	////////////////////////////////////////////////////////////
	always_ff @(posedge read_clk or negedge rstn) begin
		if (!rstn) begin
			inter_frame_en_o <= ldpc_sched_pkg::INIT_INTER_FRAME_EN;
			de_frame_start_o <= 1'b0;
		end else begin
			if (!fsm_en_i)
				inter_frame_en_o <= ldpc_sched_pkg::INIT_INTER_FRAME_EN;
			else if (((state_q == ldpc_sched_pkg::LLR_FETCH) ||
				(state_q == ldpc_sched_pkg::P2P_V)) && sched.v2c_last)
				inter_frame_en_o <= 1'b1; // last bit of a v2c pass
			else if ((state_q == ldpc_sched_pkg::VNU_PIPE) && vnu_exit)
				inter_frame_en_o <= 1'b1;
			else if (inter_frame_align_i)
				inter_frame_en_o <= 1'b0;
			if (state_q == ldpc_sched_pkg::INIT_LOAD)
				de_frame_start_o <= 1'b1;
			else if ((state_q == ldpc_sched_pkg::CNU_PIPE) && termination_i)
				de_frame_start_o <= 1'b0; // frame done, system drops termination
		end
	end

	assign sched.state     = state_q;
	assign sched.cnu_level = cnu_level_q;
	assign sched.vnu_level = vnu_level_q;
	assign sched.cnu_first = cnu_first;
	assign sched.vnu_first = vnu_first;

endmodule

// File: rtl/ctrl_strobe_gen.sv
`timescale 1ns/1ps

module ctrl_strobe_gen (
	input logic read_clk,
	input logic rstn,
	input logic fsm_en_i,
	sched_if.strobe_mp sched,
	output logic llr_fetch_o,
	output logic v2c_src_o,    // select channel llrs as v2c source
	output logic v2c_msg_en_o,
	output logic c2v_msg_en_o,
	output logic v2c_load_o,   // parallel-to-serial converter load
	output logic c2v_load_o,
	output logic dnu_rd_o,
	output logic dn_ram_re_o,
	output ldpc_sched_pkg::cnu_level_t cnu_rd_o,
	output ldpc_sched_pkg::cnu_level_t cn_ram_re_o,
	output ldpc_sched_pkg::vnu_level_t vnu_rd_o,
	output ldpc_sched_pkg::vnu_level_t vn_ram_re_o
);

	localparam int CNL = ldpc_sched_pkg::CNU_PIPELINE_LEVEL;
	localparam int VNL = ldpc_sched_pkg::VNU_PIPELINE_LEVEL;

	logic fetch_phase; // INIT_LOAD or LLR_FETCH

	////////////////////////////////////////////////////////////
	// decoded strobes
	////////////////////////////////////////////////////////////
	assign fetch_phase = (sched.state == ldpc_sched_pkg::INIT_LOAD) ||
		(sched.state == ldpc_sched_pkg::LLR_FETCH);
	assign llr_fetch_o = fetch_phase;
	assign v2c_src_o   = fetch_phase;

	always_comb begin
		v2c_msg_en_o = 1'b0;
		c2v_msg_en_o = 1'b0;
		case (sched.state)
			ldpc_sched_pkg::LLR_FETCH,
			ldpc_sched_pkg::P2P_V:         v2c_msg_en_o = 1'b1;
			ldpc_sched_pkg::LLR_FETCH_OUT,
			ldpc_sched_pkg::P2P_V_OUT:     v2c_msg_en_o = sched.v2c_busy; // drain last bit
			ldpc_sched_pkg::P2P_C:         c2v_msg_en_o = 1'b1;
			ldpc_sched_pkg::P2P_C_OUT:     c2v_msg_en_o = sched.c2v_busy;
			default: begin
				v2c_msg_en_o = 1'b0;
				c2v_msg_en_o = 1'b0;
			end
		endcase
	end

	assign v2c_load_o = sched.v2c_first;
	assign c2v_load_o = sched.c2v_first;
	// decision nodes read in the first v2c bit cycle only
	assign dnu_rd_o   = (sched.state == ldpc_sched_pkg::P2P_V) && sched.v2c_first;
	assign cnu_rd_o   = sched.cnu_level;
	assign vnu_rd_o   = sched.vnu_level;

	////////////////////////////////////////////////////////////
	// ram read-enable delay chains
	////////////////////////////////////////////////////////////
	always_ff @(posedge read_clk or negedge rstn) begin
		if (!rstn) begin
			cn_ram_re_o <= '0;
			vn_ram_re_o <= '0;
			dn_ram_re_o <= 1'b0;
		end else if (!fsm_en_i) begin
			cn_ram_re_o <= '0; // flush while held
			vn_ram_re_o <= '0;
			dn_ram_re_o <= 1'b0;
		end else begin
			cn_ram_re_o <= {cn_ram_re_o[CNL-2:0], sched.cnu_first}; // one stage per cycle
			vn_ram_re_o <= {vn_ram_re_o[VNL-2:0], sched.vnu_first};
			dn_ram_re_o <= vn_ram_re_o[VNL-1]; // dnu follows last vnu stage
		end
	end

endmodule

// File: rtl/sys_control_unit.sv
`timescale 1ns/1ps

module sys_control_unit (
	input logic read_clk,
	input logic rstn,
	input logic fsm_en_i,
	input logic termination_i,
	input logic inter_frame_align_i,
	output ldpc_sched_pkg::sched_state_e state_o,
	output logic inter_frame_en_o,
	output logic de_frame_start_o,
	output logic llr_fetch_o,
	output logic v2c_src_o,
	output logic v2c_msg_en_o,
	output logic c2v_msg_en_o,
	output logic v2c_load_o,
	output logic c2v_load_o,
	output logic dnu_rd_o,
	output logic dn_ram_re_o,
	output ldpc_sched_pkg::cnu_level_t cnu_rd_o,
	output ldpc_sched_pkg::cnu_level_t cn_ram_re_o,
	output ldpc_sched_pkg::vnu_level_t vnu_rd_o,
	output ldpc_sched_pkg::vnu_level_t vn_ram_re_o
);

	// state and timing flags shared by the three blocks
	sched_if sched_bus (.read_clk(read_clk));

	msg_psp_timer msg_psp_timer_inst (
		.read_clk (read_clk),
		.rstn     (rstn),
		.sched    (sched_bus.timer_mp)
	);

	decode_fsm decode_fsm_inst (
		.read_clk            (read_clk),
		.rstn                (rstn),
		.fsm_en_i            (fsm_en_i),
		.termination_i       (termination_i),
		.inter_frame_align_i (inter_frame_align_i),
		.inter_frame_en_o    (inter_frame_en_o),
		.de_frame_start_o    (de_frame_start_o),
		.sched               (sched_bus.fsm_mp)
	);

	ctrl_strobe_gen ctrl_strobe_gen_inst (
		.read_clk     (read_clk),
		.rstn         (rstn),
		.fsm_en_i     (fsm_en_i),
		.sched        (sched_bus.strobe_mp),
		.llr_fetch_o  (llr_fetch_o),
		.v2c_src_o    (v2c_src_o),
		.v2c_msg_en_o (v2c_msg_en_o),
		.c2v_msg_en_o (c2v_msg_en_o),
		.v2c_load_o   (v2c_load_o),
		.c2v_load_o   (c2v_load_o),
		.dnu_rd_o     (dnu_rd_o),
		.dn_ram_re_o  (dn_ram_re_o),
		.cnu_rd_o     (cnu_rd_o),
		.cn_ram_re_o  (cn_ram_re_o),
		.vnu_rd_o     (vnu_rd_o),
		.vn_ram_re_o  (vn_ram_re_o)
	);

	assign state_o = sched_bus.state;

endmodule

// File: dv/sys_control_unit_assertions.sv
`timescale 1ns/1ps

module sys_control_unit_assertions (
	input logic read_clk,
	input logic rstn,
	input logic termination_i,
	input ldpc_sched_pkg::sched_state_e state_o,
	input ldpc_sched_pkg::cnu_level_t cn_ram_re_o,
	input ldpc_sched_pkg::vnu_level_t vn_ram_re_o,
	input logic v2c_msg_en_o,
	input logic c2v_msg_en_o,
	input logic llr_fetch_o,
	input logic v2c_src_o
);

	int unsigned fail_count = 0; // number of failed assertions

	// read enables walk as a single token through each chain
	cn_re_onehot0: assert property (@(posedge read_clk) disable iff (!rstn)
		$onehot0(cn_ram_re_o))
	else begin
		$error("cn_ram_re has more than one bit set");
		fail_count++;
	end
	vn_re_onehot0: assert property (@(posedge read_clk) disable iff (!rstn)
		$onehot0(vn_ram_re_o))
	else begin
		$error("vn_ram_re has more than one bit set");
		fail_count++;
	end

	// only one converter shifts at a time
	msg_en_excl: assert property (@(posedge read_clk) disable iff (!rstn)
		!(v2c_msg_en_o && c2v_msg_en_o))
	else begin
		$error("v2c and c2v message enables overlap");
		fail_count++;
	end

	term_restart: assert property (@(posedge read_clk) disable iff (!rstn)
		termination_i |=> (state_o == ldpc_sched_pkg::INIT_LOAD))
	else begin
		$error("termination did not restart the schedule");
		fail_count++;
	end

	// both fetch strobes are high exactly in the channel fetch states
	fetch_src_eq: assert property (@(posedge read_clk) disable iff (!rstn)
		(llr_fetch_o == v2c_src_o) &&
		(v2c_src_o == ((state_o == ldpc_sched_pkg::INIT_LOAD) ||
		(state_o == ldpc_sched_pkg::LLR_FETCH))))
	else begin
		$error("llr_fetch or v2c_src does not match the fetch states");
		fail_count++;
	end

endmodule

bind sys_control_unit sys_control_unit_assertions sys_control_unit_assertions_inst (
	.read_clk      (read_clk),
	.rstn          (rstn),
	.termination_i (termination_i),
	.state_o       (state_o),
	.cn_ram_re_o   (cn_ram_re_o),
	.vn_ram_re_o   (vn_ram_re_o),
	.v2c_msg_en_o  (v2c_msg_en_o),
	.c2v_msg_en_o  (c2v_msg_en_o),
	.llr_fetch_o   (llr_fetch_o),
	.v2c_src_o     (v2c_src_o)
);

// File: dv/tb_sys_control_unit.sv
`timescale 1ns/1ps

module tb_sys_control_unit;

	localparam int Q   = ldpc_sched_pkg::QUAN_SIZE;
	localparam int CNL = ldpc_sched_pkg::CNU_PIPELINE_LEVEL;
	localparam int VNL = ldpc_sched_pkg::VNU_PIPELINE_LEVEL;
	localparam int C2V_START   = CNL + 1;           // first P2P_C cycle after CNU_PIPE entry
	localparam int VNU_START   = C2V_START + Q + 1; // VNU_PIPE entry
	localparam int V2C_START   = VNU_START + VNL + 1;
	localparam int ITER_CYCLES = V2C_START + Q + 1; // one loop is 18 cycles by default
	localparam int RESET_CYCLES   = 10;
	localparam int TIMEOUT_CYCLES = 2000;

	logic read_clk;
	logic rstn;
	logic fsm_en;
	logic termination;
	logic inter_frame_align;
	ldpc_sched_pkg::sched_state_e state;
	logic inter_frame_en, de_frame_start, llr_fetch, v2c_src;
	logic v2c_msg_en, c2v_msg_en, v2c_load, c2v_load, dnu_rd, dn_ram_re;
	ldpc_sched_pkg::cnu_level_t cnu_rd, cn_ram_re;
	ldpc_sched_pkg::vnu_level_t vnu_rd, vn_ram_re;
	ldpc_sched_pkg::sched_state_e exp_states[$]; // expected state per cycle
	int cycle_count = 0;
	int error_count = 0;
	integer seed;

	sys_control_unit sys_control_unit_inst (
		.read_clk            (read_clk),
		.rstn                (rstn),
		.fsm_en_i            (fsm_en),
		.termination_i       (termination),
		.inter_frame_align_i (inter_frame_align),
		.state_o             (state),
		.inter_frame_en_o    (inter_frame_en),
		.de_frame_start_o    (de_frame_start),
		.llr_fetch_o         (llr_fetch),
		.v2c_src_o           (v2c_src),
		.v2c_msg_en_o        (v2c_msg_en),
		.c2v_msg_en_o        (c2v_msg_en),
		.v2c_load_o          (v2c_load),
		.c2v_load_o          (c2v_load),
		.dnu_rd_o            (dnu_rd),
		.dn_ram_re_o         (dn_ram_re),
		.cnu_rd_o            (cnu_rd),
		.cn_ram_re_o         (cn_ram_re),
		.vnu_rd_o            (vnu_rd),
		.vn_ram_re_o         (vn_ram_re)
	);

	initial read_clk = 1'b0;
	always #4 read_clk = ~read_clk; // 8 ns period

	always @(posedge read_clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
			fail_run($sformatf("TIMEOUT run did not finish in %0d cycles", TIMEOUT_CYCLES));
	end

	always @(negedge read_clk) begin
		if (sys_control_unit_inst.sys_control_unit_assertions_inst.fail_count != 0)
			fail_run("a bound assertion on the DUT outputs failed");
	end

	////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////
	task automatic fail_run(input string why);
		error_count++;
		$display("%s", why);
		$display("Some tests failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_val(input string test, input string what, input int exp, input int act);
		assert (exp == act) else
			fail_run($sformatf("CHECK FAILED %s %s expected %0h actual %0h", test, what, exp, act));
	endtask

	task automatic push_state(input ldpc_sched_pkg::sched_state_e s, input int n);
		repeat (n) exp_states.push_back(s);
	endtask

	// returns at the negedge of the first cycle spent in target
	task automatic wait_state_entry(input ldpc_sched_pkg::sched_state_e target);
		ldpc_sched_pkg::sched_state_e prev;
		int n;
		prev = state;
		n = 0;
		@(negedge read_clk);
		while (!((state == target) && (prev != target))) begin
			if (n == 3 * ITER_CYCLES)
				fail_run($sformatf("state %s was never entered", target.name()));
			prev = state;
			n++;
			@(negedge read_clk);
		end
	endtask

	task automatic check_idle(input string test);
		check_val(test, "state", ldpc_sched_pkg::INIT_LOAD, state);
		check_val(test, "cn_ram_re", 0, cn_ram_re);
		check_val(test, "vn_ram_re", 0, vn_ram_re);
		check_val(test, "dn_ram_re", 0, dn_ram_re);
		check_val(test, "inter_frame_en", ldpc_sched_pkg::INIT_INTER_FRAME_EN, inter_frame_en);
		check_val(test, "v2c_msg_en", 0, v2c_msg_en);
		check_val(test, "c2v_msg_en", 0, c2v_msg_en);
		check_val(test, "c2v_load", 0, c2v_load);
		check_val(test, "dnu_rd", 0, dnu_rd);
		check_val(test, "llr_fetch", 1, llr_fetch); // INIT_LOAD still fetches
		check_val(test, "v2c_src", 1, v2c_src);
	endtask

	task automatic pulse_align(input string test);
		check_val(test, "inter_frame_en before align", 1, inter_frame_en);
		inter_frame_align = 1'b1;
		@(negedge read_clk);
		inter_frame_align = 1'b0;
		check_val(test, "inter_frame_en after align", 0, inter_frame_en);
	endtask

	////////////////////////////////////////////////////////////
	// directed tests
	////////////////////////////////////////////////////////////
	task automatic reset_hold_test();
		repeat (RESET_CYCLES) @(negedge read_clk);
		check_idle("reset_hold");
		check_val("reset_hold", "de_frame_start", 0, de_frame_start);
		rstn = 1'b1;
		repeat (6) begin // fsm_en still low
			@(negedge read_clk);
			check_idle("reset_hold");
		end
	endtask

	task automatic state_sequence_test();
		exp_states.delete();
		push_state(ldpc_sched_pkg::INIT_LOAD, 1);
		push_state(ldpc_sched_pkg::LLR_FETCH, Q);
		push_state(ldpc_sched_pkg::LLR_FETCH_OUT, 1);
		repeat (2) begin
			push_state(ldpc_sched_pkg::CNU_PIPE, CNL);
			push_state(ldpc_sched_pkg::CNU_OUT, 1);
			push_state(ldpc_sched_pkg::P2P_C, Q);
			push_state(ldpc_sched_pkg::P2P_C_OUT, 1);
			push_state(ldpc_sched_pkg::VNU_PIPE, VNL);
			push_state(ldpc_sched_pkg::VNU_OUT, 1);
			push_state(ldpc_sched_pkg::P2P_V, Q);
			push_state(ldpc_sched_pkg::P2P_V_OUT, 1);
		end
		check_val("state_sequence", "state cycle 0", exp_states[0], state);
		fsm_en = 1'b1; // leaves INIT_LOAD on the next edge
		for (int i = 1; i < exp_states.size(); i++) begin
			@(negedge read_clk);
			check_val("state_sequence", $sformatf("state cycle %0d", i), exp_states[i], state);
		end
	endtask

	task automatic message_strobe_test();
		int v2c_cnt;
		int c2v_cnt;
		v2c_cnt = 0;
		c2v_cnt = 0;
		wait_state_entry(ldpc_sched_pkg::CNU_PIPE);
		for (int i = 0; i < ITER_CYCLES; i++) begin
			if (i > 0)
				@(negedge read_clk);
			v2c_cnt += v2c_msg_en;
			c2v_cnt += c2v_msg_en;
			check_val("message_strobe", $sformatf("c2v_load %0d", i), i == C2V_START, c2v_load);
			check_val("message_strobe", $sformatf("v2c_load %0d", i), i == V2C_START, v2c_load);
			check_val("message_strobe", $sformatf("dnu_rd %0d", i), i == V2C_START, dnu_rd);
			if (i == C2V_START)
				check_val("message_strobe", "state at c2v load", ldpc_sched_pkg::P2P_C, state);
			if (i == V2C_START)
				check_val("message_strobe", "state at v2c load", ldpc_sched_pkg::P2P_V, state);
		end
		check_val("message_strobe", "v2c_msg_en cycles", Q + 1, v2c_cnt);
		check_val("message_strobe", "c2v_msg_en cycles", Q + 1, c2v_cnt);
	endtask

	task automatic read_enable_test();
		int exp_cn;
		int exp_vn;
		wait_state_entry(ldpc_sched_pkg::CNU_PIPE);
		for (int i = 0; i < ITER_CYCLES; i++) begin
			if (i > 0)
				@(negedge read_clk);
			exp_cn = (i >= 1 && i <= CNL) ? (1 << (i - 1)) : 0; // bit k at k+1
			exp_vn = (i > VNU_START && i <= VNU_START + VNL) ? (1 << (i - VNU_START - 1)) : 0;
			check_val("read_enable", $sformatf("cn_ram_re %0d", i), exp_cn, cn_ram_re);
			check_val("read_enable", $sformatf("vn_ram_re %0d", i), exp_vn, vn_ram_re);
			check_val("read_enable", $sformatf("dn_ram_re %0d", i),
				i == VNU_START + VNL + 1, dn_ram_re);
			// level walks from the cycle after pipe entry into the *_OUT cycle
			check_val("read_enable", $sformatf("cnu_rd %0d", i), exp_cn, cnu_rd);
			check_val("read_enable", $sformatf("vnu_rd %0d", i), exp_vn, vnu_rd);
		end
	endtask

	task automatic termination_test();
		int r;
		wait_state_entry(ldpc_sched_pkg::CNU_PIPE);
		check_val("termination", "de_frame_start", 1, de_frame_start);
		pulse_align("termination"); // clear it so the next rise is visible
		r = 1 + ($unsigned($random(seed)) % (CNL - 1)); // cycle 1..CNL-1 of CNU_PIPE
		repeat (r - 1) @(negedge read_clk);
		check_val("termination", "state before termination", ldpc_sched_pkg::CNU_PIPE, state);
		termination = 1'b1;
		@(negedge read_clk);
		termination = 1'b0;
		check_val("termination", "state", ldpc_sched_pkg::INIT_LOAD, state);
		check_val("termination", "de_frame_start cleared", 0, de_frame_start);
		@(negedge read_clk);
		check_val("termination", "state", ldpc_sched_pkg::LLR_FETCH, state);
		check_val("termination", "de_frame_start set", 1, de_frame_start);
		check_val("termination", "inter_frame_en in fetch", 0, inter_frame_en);
		for (int i = 1; i < Q; i++) begin
			@(negedge read_clk);
			check_val("termination", "inter_frame_en in fetch", 0, inter_frame_en);
		end
		@(negedge read_clk);
		check_val("termination", "state", ldpc_sched_pkg::LLR_FETCH_OUT, state);
		check_val("termination", "inter_frame_en after fetch", 1, inter_frame_en);
		wait_state_entry(ldpc_sched_pkg::CNU_PIPE);
		pulse_align("termination");
	endtask

	initial begin
		seed = 32'h1b36;
		rstn = 1'b0;
		fsm_en = 1'b0;
		termination = 1'b0;
		inter_frame_align = 1'b0;
		reset_hold_test();
		state_sequence_test();
		message_strobe_test();
		read_enable_test();
		termination_test();
		@(negedge read_clk);
		if ((error_count == 0) &&
			(sys_control_unit_inst.sys_control_unit_assertions_inst.fail_count == 0))
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

// File: sys_control_unit.f
rtl/ldpc_sched_pkg.sv
rtl/sched_if.sv
rtl/msg_psp_timer.sv
rtl/decode_fsm.sv
rtl/ctrl_strobe_gen.sv
rtl/sys_control_unit.sv
dv/sys_control_unit_assertions.sv
dv/tb_sys_control_unit.sv

// File: Bender.yml
package:
  name: sys_control_unit

sources:
  - rtl/ldpc_sched_pkg.sv
  - rtl/sched_if.sv
  - rtl/msg_psp_timer.sv
  - rtl/decode_fsm.sv
  - rtl/ctrl_strobe_gen.sv
  - rtl/sys_control_unit.sv
  - target: simulation
    files:
      - dv/sys_control_unit_assertions.sv
      - dv/tb_sys_control_unit.sv
